/* Bender.yml */
package:
  name: mbus_layer

sources:
  - mbus_frame_pkg.sv
  - mbus_power_pkg.sv
  - mbus_node_ctrl.sv
  - mbus_tx_arbiter.sv
  - mbus_ext_int.sv
  - mbus_sleep_ctrl.sv
  - mbus_layer.sv
  - target: simulation
    files:
      - tb_mbus_layer.sv

/* mbus_ext_int.sv */
module mbus_ext_int
	import mbus_frame_pkg::*;
#(
	parameter logic [ADDR_WIDTH-1:0] ADDRESS = 8'h5a
) (
	input logic clk_ext,
	input logic reset,
	input logic req_int,
	input logic int_done,
	input logic int_retry,
	output logic int_req,
	output mbus_frame_u int_frame
);

	logic req_q;
	logic req_rise;
	logic pending;
	logic [SEQ_WIDTH-1:0] seq;	// interrupts announced so far

	assign req_rise = req_int && !req_q;

	always_ff @(posedge clk_ext) begin
		if (reset) begin
			req_q <= 1'b0;
			pending <= 1'b0;
			seq <= '0;
		end else begin
			req_q <= req_int;
			if (req_rise) begin
				pending <= 1'b1;	// a new edge outranks a finishing send
			end else if (int_done) begin
				pending <= 1'b0;
			end
			if (int_done) begin
				seq <= seq + 1'b1;
			end
		end
	end

	assign int_req = pending;	// held across retries

	always_comb begin
		int_frame.intr.addr = BROADCAST_ADDR;
		int_frame.intr.reserved = '0;
		int_frame.intr.src = ADDRESS;
		int_frame.intr.seq = seq;
	end

	// the arbiter reports outcomes only for an interrupt we asked for
	outcome_a: assert property (@(posedge clk_ext) disable iff (reset)
		(int_done || int_retry) |-> pending);

endmodule

/* mbus_frame_pkg.sv */
package mbus_frame_pkg;

	localparam int ADDR_WIDTH = 8;
	localparam int DATA_WIDTH = 32;
	localparam int FRAME_BITS = ADDR_WIDTH + DATA_WIDTH;	// addr + data, no framing bits
	localparam int WIRE_BITS = FRAME_BITS + 2;	// start bit + frame + stop bit

	localparam int SEQ_WIDTH = 12;	// interrupt counter
	localparam int RSVD_WIDTH = DATA_WIDTH - ADDR_WIDTH - SEQ_WIDTH;

	localparam logic [ADDR_WIDTH-1:0] BROADCAST_ADDR = 8'hff;	// accepted by every node

	// plain message
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
	} mbus_msg_t;

	// interrupt announcement, same 40 bits read differently
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [RSVD_WIDTH-1:0] reserved;	// zero
		logic [ADDR_WIDTH-1:0] src;	// address of the interrupting node
		logic [SEQ_WIDTH-1:0] seq;
	} mbus_intr_t;

	typedef union packed {
		mbus_msg_t msg;
		mbus_intr_t intr;
	} mbus_frame_u;

endpackage

/* mbus_layer.sv */
module mbus_layer
	import mbus_frame_pkg::*;
#(
	parameter logic [ADDR_WIDTH-1:0] ADDRESS = 8'h5a,
	parameter logic [15:0] THRESHOLD = 16'h05ff,
	parameter logic [3:0] IDLE_GAP = 4'd4
) (
	input logic clk_ext,
	input logic reset,
	input logic din,
	output logic dout,
	input logic [ADDR_WIDTH-1:0] tx_addr,
	input logic [DATA_WIDTH-1:0] tx_data,
	input logic tx_req,
	input logic tx_priority,
	output logic tx_ack,
	output logic tx_succ,
	output logic tx_fail,
	output logic [ADDR_WIDTH-1:0] rx_addr,
	output logic [DATA_WIDTH-1:0] rx_data,
	output logic rx_req,
	input logic rx_ack,
	output logic rx_broadcast,
	output logic rx_fail,
	output logic lc_power_on,
	output logic lc_release_clk,
	output logic lc_release_rst,
	output logic lc_release_iso,
	input logic req_int,
	input logic wakeup_proc
);

	logic node_awake;
	logic tx_go;
	logic tx_prio;
	mbus_frame_u tx_frame;
	logic tx_start;
	logic tx_end_ok;
	logic tx_end_collide;
	logic bus_busy;
	logic req_pending;
	logic int_req;
	mbus_frame_u int_frame;
	logic int_done;
	logic int_retry;

	assign node_awake = lc_release_iso;	// logic enabled once isolation lifts

	mbus_node_ctrl #(
		.ADDRESS(ADDRESS),
		.IDLE_GAP(IDLE_GAP)
	) node0 (
		.clk_ext(clk_ext),
		.reset(reset),
		.din(din),
		.dout(dout),	// always-on path
		.node_awake(node_awake),
		.tx_go(tx_go),
		.tx_prio(tx_prio),
		.tx_frame(tx_frame),
		.tx_start(tx_start),
		.tx_end_ok(tx_end_ok),
		.tx_end_collide(tx_end_collide),
		.rx_addr(rx_addr),
		.rx_data(rx_data),
		.rx_req(rx_req),
		.rx_ack(rx_ack),
		.rx_broadcast(rx_broadcast),
		.rx_fail(rx_fail),
		.bus_busy(bus_busy)
	);

	mbus_tx_arbiter arb0 (
		.clk_ext(clk_ext),
		.reset(reset),
		.tx_req(tx_req),
		.tx_addr(tx_addr),
		.tx_data(tx_data),
		.tx_priority(tx_priority),
		.int_req(int_req),
		.int_frame(int_frame),
		.tx_start(tx_start),
		.tx_end_ok(tx_end_ok),
		.tx_end_collide(tx_end_collide),
		.tx_go(tx_go),
		.tx_prio(tx_prio),
		.tx_frame(tx_frame),
		.tx_ack(tx_ack),
		.tx_succ(tx_succ),
		.tx_fail(tx_fail),
		.int_done(int_done),
		.int_retry(int_retry),
		.req_pending(req_pending)	// also a wake cause
	);

	mbus_ext_int #(
		.ADDRESS(ADDRESS)
	) int0 (
		.clk_ext(clk_ext),
		.reset(reset),
		.req_int(req_int),
		.int_done(int_done),
		.int_retry(int_retry),
		.int_req(int_req),
		.int_frame(int_frame)
	);

	mbus_sleep_ctrl #(
		.THRESHOLD(THRESHOLD)
	) sleep0 (
		.clk_ext(clk_ext),
		.reset(reset),
		.din(din),
		.wakeup_proc(wakeup_proc),
		.req_int(req_int),
		.bus_busy(bus_busy),
		.req_pending(req_pending),
		.lc_power_on(lc_power_on),
		.lc_release_clk(lc_release_clk),
		.lc_release_rst(lc_release_rst),
		.lc_release_iso(lc_release_iso)
	);

endmodule

/* mbus_node_ctrl.sv */
module mbus_node_ctrl
	import mbus_frame_pkg::*;
#(
	parameter logic [ADDR_WIDTH-1:0] ADDRESS = 8'h5a,
	parameter logic [3:0] IDLE_GAP = 4'd4
) (
	input logic clk_ext,
	input logic reset,
	input logic din,
	output logic dout,
	input logic node_awake,
	input logic tx_go,
	input logic tx_prio,
	input mbus_frame_u tx_frame,
	output logic tx_start,
	output logic tx_end_ok,
	output logic tx_end_collide,
	output logic [ADDR_WIDTH-1:0] rx_addr,
	output logic [DATA_WIDTH-1:0] rx_data,
	output logic rx_req,
	input logic rx_ack,
	output logic rx_broadcast,
	output logic rx_fail,
	output logic bus_busy
);

	localparam int CNT_WIDTH = $clog2(WIRE_BITS);

	logic [3:0] idle_cnt;	// high din cycles so far, saturates
	logic [3:0] gap_req;
	logic idle_ok;

	logic tx_active;
	logic [CNT_WIDTH-1:0] tx_cnt;	// wire bit now on dout, 0 = start bit
	logic [FRAME_BITS-1:0] tx_shift;
	logic collide;

	logic rx_busy;	// inside a frame on din
	logic rx_keep;	// frame began while awake
	logic [CNT_WIDTH-1:0] rx_cnt;
	mbus_frame_u rx_shift;
	logic rx_stop;
	logic addr_hit;
	logic bcast_hit;
	logic rx_take;
	logic rx_hold;
	logic rx_release;

	always_ff @(posedge clk_ext) begin
		if (reset) begin
			idle_cnt <= '0;
		end else if (!din) begin
			idle_cnt <= '0;
		end else if (idle_cnt != 4'hf) begin
			idle_cnt <= idle_cnt + 4'd1;
		end
	end

	// the current high cycle counts toward the gap
	assign gap_req = tx_prio ? 4'd1 : IDLE_GAP;
	assign idle_ok = din && (idle_cnt >= gap_req - 4'd1);

	assign tx_start = tx_go && node_awake && !tx_active && !rx_busy && idle_ok;
	assign collide = tx_active && (tx_cnt != '0) && !din;	// start bit itself is not checked

	always_ff @(posedge clk_ext) begin
		if (reset) begin
			tx_active <= 1'b0;
			tx_cnt <= '0;
			tx_end_ok <= 1'b0;
			tx_end_collide <= 1'b0;
			dout <= 1'b1;
		end else begin
			tx_end_ok <= 1'b0;
			tx_end_collide <= 1'b0;
			if (tx_start) begin
				tx_active <= 1'b1;
				tx_cnt <= '0;
				dout <= 1'b0;	// start bit
			end else if (collide) begin
				tx_active <= 1'b0;
				tx_end_collide <= 1'b1;
				dout <= din;	// upstream owns the ring now
			end else if (tx_active && tx_cnt == CNT_WIDTH'(WIRE_BITS - 1)) begin
				tx_active <= 1'b0;
				tx_end_ok <= 1'b1;
				dout <= din;
			end else if (tx_active) begin
				tx_cnt <= tx_cnt + 1'b1;
				dout <= tx_shift[FRAME_BITS-1];
			end else begin
				dout <= din;	// plain forwarding
			end
		end
	end

	always_ff @(posedge clk_ext) begin
		if (tx_start) begin
			tx_shift <= tx_frame;
		end else if (tx_active) begin
			tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b1};	// fill supplies the stop bit
		end
	end

	assign rx_stop = rx_busy && (rx_cnt == CNT_WIDTH'(FRAME_BITS));
	assign addr_hit = rx_shift.msg.addr == ADDRESS;
	assign bcast_hit = rx_shift.msg.addr == BROADCAST_ADDR;
	assign rx_take = rx_stop && din && rx_keep && (addr_hit || bcast_hit);
	assign rx_hold = rx_req && !rx_ack;	// last frame not yet taken
	assign rx_release = rx_req && rx_ack;

	always_ff @(posedge clk_ext) begin
		if (reset) begin
			rx_busy <= 1'b0;
			rx_keep <= 1'b0;
			rx_cnt <= '0;
		end else if (!rx_busy) begin
			if (!din) begin
				rx_busy <= 1'b1;
				rx_keep <= node_awake;	// asleep: track framing, deliver nothing
				rx_cnt <= '0;
			end
		end else if (rx_stop) begin
			rx_busy <= 1'b0;
		end else begin
			rx_cnt <= rx_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_ext) begin
		if (rx_busy && !rx_stop) begin
			rx_shift <= {rx_shift[FRAME_BITS-2:0], din};	// msb first
		end
	end

	always_ff @(posedge clk_ext) begin
		if (reset) begin
			rx_req <= 1'b0;
			rx_broadcast <= 1'b0;
			rx_fail <= 1'b0;
		end else begin
			rx_fail <= 1'b0;
			if (rx_take && rx_hold) begin
				rx_fail <= 1'b1;	// dropped
			end else if (rx_take) begin
				rx_req <= 1'b1;
				rx_broadcast <= bcast_hit;
			end else if (rx_release) begin
				rx_req <= 1'b0;
				rx_broadcast <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_ext) begin
		if (rx_take && !rx_hold) begin
			rx_addr <= rx_shift.msg.addr;
			rx_data <= rx_shift.msg.data;
		end else if (rx_release) begin
			rx_addr <= '0;
			rx_data <= '0;
		end
	end

	assign bus_busy = rx_busy || tx_active;

	end_excl_a: assert property (@(posedge clk_ext) disable iff (reset)
		!(tx_end_ok && tx_end_collide));

	// the failing frame must find the earlier one still waiting
	fail_pend_a: assert property (@(posedge clk_ext) disable iff (reset)
		rx_fail |-> rx_req);

endmodule

/* mbus_power_pkg.sv */
package mbus_power_pkg;

	typedef enum logic [1:0] {
		AWAKE,
		GOING_DOWN,
		ASLEEP,
		GOING_UP
	} power_state_e;

	localparam int STEP_CYCLES = 2;	// spacing of layer-control edges
	localparam int LC_LINES = 4;	// iso, rst, clk, power_on
	localparam int STEP_CNT_WIDTH = $clog2(STEP_CYCLES + 1);

endpackage

/* mbus_sleep_ctrl.sv */
module mbus_sleep_ctrl
	import mbus_power_pkg::*;
#(
	parameter logic [15:0] THRESHOLD = 16'h05ff
) (
	input logic clk_ext,
	input logic reset,
	input logic din,
	input logic wakeup_proc,
	input logic req_int,
	input logic bus_busy,
	input logic req_pending,
	output logic lc_power_on,
	output logic lc_release_clk,
	output logic lc_release_rst,
	output logic lc_release_iso
);

	power_state_e state;
	logic [15:0] idle_cnt;
	logic [STEP_CNT_WIDTH-1:0] step_cnt;
	logic [LC_LINES-1:0] lc;	// thermometer, bit 0 iso up to bit 3 power_on
	logic quiet;
	logic wake;
	logic step_due;

	assign quiet = din && !bus_busy && !req_pending && !wakeup_proc;
	assign wake = !din || wakeup_proc || req_int || req_pending;
	assign step_due = step_cnt == STEP_CNT_WIDTH'(STEP_CYCLES - 1);

	always_ff @(posedge clk_ext) begin
		if (reset) begin
			state <= AWAKE;
			lc <= '1;
			step_cnt <= '0;
			idle_cnt <= '0;
		end else begin
			case (state)
				AWAKE: begin
					step_cnt <= '0;
					if (!quiet) begin
						idle_cnt <= '0;
					end else if (idle_cnt == THRESHOLD - 16'd1) begin
						idle_cnt <= '0;
						lc <= lc << 1;	// isolation drops first
						state <= GOING_DOWN;
					end else begin
						idle_cnt <= idle_cnt + 16'd1;
					end
				end
				GOING_DOWN: begin
					if (wake) begin
						step_cnt <= '0;
						state <= GOING_UP;	// back up from where we are
					end else if (step_due) begin
						step_cnt <= '0;
						lc <= lc << 1;
						if (lc[LC_LINES-2:0] == '0) begin
							state <= ASLEEP;	// power_on was the last one
						end
					end else begin
						step_cnt <= step_cnt + 1'b1;
					end
				end
				ASLEEP: begin
					if (wake) begin
						lc <= {1'b1, lc[LC_LINES-1:1]};	// power first
						step_cnt <= '0;
						state <= GOING_UP;
					end
				end
				GOING_UP: begin
					if (step_due) begin
						step_cnt <= '0;
						lc <= {1'b1, lc[LC_LINES-1:1]};
						if (lc[LC_LINES-1:1] == '1) begin
							state <= AWAKE;
						end
					end else begin
						step_cnt <= step_cnt + 1'b1;
					end
				end
				default: begin
					state <= AWAKE;
				end
			endcase
		end
	end

	assign lc_release_iso = lc[0];
	assign lc_release_rst = lc[1];
	assign lc_release_clk = lc[2];
	assign lc_power_on = lc[3];

	iso_power_a: assert property (@(posedge clk_ext) disable iff (reset)
		lc_release_iso |-> lc_power_on);

endmodule

/* mbus_tx_arbiter.sv */
module mbus_tx_arbiter
	import mbus_frame_pkg::*;
(
	input logic clk_ext,
	input logic reset,
	input logic tx_req,
	input logic [ADDR_WIDTH-1:0] tx_addr,
	input logic [DATA_WIDTH-1:0] tx_data,
	input logic tx_priority,
	input logic int_req,
	input mbus_frame_u int_frame,
	input logic tx_start,
	input logic tx_end_ok,
	input logic tx_end_collide,
	output logic tx_go,
	output logic tx_prio,
	output mbus_frame_u tx_frame,
	output logic tx_ack,
	output logic tx_succ,
	output logic tx_fail,
	output logic int_done,
	output logic int_retry,
	output logic req_pending
);

	logic locked;	// frame on the wire
	logic grant_q;	// owner of the frame on the wire, 1 = interrupt
	logic sel_int;
	logic tx_end;
	mbus_frame_u layer_frame;

	assign tx_end = tx_end_ok || tx_end_collide;

	// interrupt first unless the layer asks for priority
	assign sel_int = locked ? grant_q : (int_req && !(tx_req && tx_priority));

	always_comb begin
		layer_frame.msg.addr = tx_addr;
		layer_frame.msg.data = tx_data;
	end

	assign tx_frame = sel_int ? int_frame : layer_frame;
	assign tx_go = (tx_req || int_req) && !locked;
	assign tx_prio = !sel_int && tx_priority;
	assign req_pending = tx_req || int_req;

	assign tx_ack = tx_start && !sel_int;
	assign tx_succ = tx_end_ok && !grant_q;
	assign tx_fail = tx_end_collide && !grant_q;
	assign int_done = tx_end_ok && grant_q;
	assign int_retry = tx_end_collide && grant_q;

	always_ff @(posedge clk_ext) begin
		if (reset) begin
			locked <= 1'b0;
			grant_q <= 1'b0;
		end else if (tx_start) begin
			locked <= 1'b1;
			grant_q <= sel_int;
		end else if (tx_end) begin
			locked <= 1'b0;
		end
	end

	grant_hold_a: assert property (@(posedge clk_ext) disable iff (reset)
		locked && !tx_end |=> locked && $stable(grant_q));

endmodule

/* tb_mbus_layer.sv */
module tb_mbus_layer
	import mbus_frame_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [7:0] NODE_ADDR = 8'h5a;
	localparam int IDLE_LIMIT = 64;
	localparam int STEP = 2;	// lc edge spacing

	logic clk = 1'b0;
	logic reset, din, dout, tx_req, tx_priority, tx_ack, tx_succ, tx_fail;
	logic [7:0] tx_addr, rx_addr;
	logic [31:0] tx_data, rx_data;
	logic rx_req, rx_ack, rx_broadcast, rx_fail, req_int, wakeup_proc;
	logic lc_power_on, lc_release_clk, lc_release_rst, lc_release_iso;

	logic [15:0] lfsr = 16'd24596;
	logic [41:0] exp_q[$];	// wire sequences expected on dout in order
	logic [41:0] cur_wire;
	int bit_idx;
	logic in_tx = 1'b0;
	logic check_on = 1'b0;
	logic din_last = 1'b1;
	int succ_cnt = 0;
	int fail_cnt = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_err0 = 0;
	string test_name = "reset";

	mbus_layer #(.ADDRESS(NODE_ADDR), .THRESHOLD(16'd64), .IDLE_GAP(4'd4)) dut_i (
		.clk_ext(clk),
		.*
	);

	always #5 clk = ~clk;

	initial begin
		#(6 * 400 * 10);
		$display("timeout: the tests did not finish in the expected time");
		$display("RESULT: FAIL");
		$finish;
	end

	function automatic logic take_bit();
		logic fb;
		fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];	// x^16 + x^14 + x^13 + x^11 + 1
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_word(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], take_bit()};
		return v;
	endfunction

	// start bit, address and data msb first, stop bit
	function automatic logic [41:0] wire_ref(logic [7:0] a, logic [31:0] d);
		return {1'b0, a, d, 1'b1};
	endfunction

	// 0 ignored, 1 accepted, 2 dropped with rx_fail
	function automatic int rx_ref(logic [7:0] a, logic pending);
		if (a != NODE_ADDR && a != 8'hff)
			return 0;
		return pending ? 2 : 1;
	endfunction

	function automatic logic [41:0] int_wire(logic [11:0] seq);
		mbus_frame_u f;
		f.intr.addr = 8'hff;
		f.intr.reserved = '0;
		f.intr.src = NODE_ADDR;
		f.intr.seq = seq;
		return wire_ref(f.msg.addr, f.msg.data);	// same bits through the msg view
	endfunction

	task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
		checks++;
		if (expected !== actual) begin
			$display("CHECK FAILED %s: %s expected %0h actual %0h", test_name, what, expected,
				actual);
			errors++;
		end
	endtask

	// dout follows din by one cycle unless an expected frame is on the wire
	always @(negedge clk) begin
		if (check_on) begin
			if (tx_succ)
				succ_cnt++;
			if (tx_fail) begin
				fail_cnt++;
				in_tx = 1'b0;	// collided so back to forwarding
			end
			if (in_tx) begin
				check_value("dout frame bit", cur_wire[bit_idx], dout);
				if (bit_idx == 0)
					in_tx = 1'b0;
				else
					bit_idx--;
			end else if (exp_q.size() > 0 && din_last && !dout) begin
				cur_wire = exp_q.pop_front();
				bit_idx = 40;
				in_tx = 1'b1;
			end else begin
				check_value("dout forwarded", din_last, dout);
			end
		end
		din_last = din;
	end

	task automatic begin_test(string name);
		test_name = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		tests++;
		$display("test %s finished with %0d errors", test_name, errors - test_err0);
	endtask

	task automatic send_frame(logic [7:0] a, logic [31:0] d);
		logic [41:0] w;
		w = wire_ref(a, d);
		for (int i = 41; i >= 0; i--) begin
			@(posedge clk);
			din <= w[i];
		end
		@(posedge clk);
		din <= 1'b1;
	endtask

	task automatic start_layer(logic [7:0] a, logic [31:0] d, logic prio);
		int n;
		n = 0;
		@(posedge clk);
		tx_addr <= a;
		tx_data <= d;
		tx_priority <= prio;
		tx_req <= 1'b1;
		@(negedge clk);
		while (!tx_ack && n < 300) begin
			@(negedge clk);
			n++;
		end
		if (!tx_ack) begin
			$display("test %s: the layer request was never acknowledged", test_name);
			errors++;
		end
		@(posedge clk);
		tx_req <= 1'b0;
		tx_priority <= 1'b0;
		@(negedge clk);
		check_value("start bit after tx_ack", 0, dout);
	endtask

	task automatic wait_tx_done();
		int n;
		n = 0;
		@(posedge clk);
		while ((exp_q.size() != 0 || in_tx) && n < 300) begin
			@(posedge clk);
			n++;
		end
		if (exp_q.size() != 0 || in_tx) begin
			$display("test %s: an expected frame never finished on dout", test_name);
			errors++;
		end
		repeat (3) @(posedge clk);
	endtask

	task automatic pulse_int();
		@(posedge clk);
		req_int <= 1'b1;
		@(posedge clk);
		req_int <= 1'b0;
	endtask

	task automatic ack_rx();
		@(posedge clk);
		rx_ack <= 1'b1;
		@(posedge clk);
		rx_ack <= 1'b0;
	endtask

	// cycle count at which each lc line (iso, rst, clk, power_on) reaches level
	task automatic watch_lc(logic level, output int t[4]);
		int n;
		logic [3:0] lc;
		n = 0;
		for (int i = 0; i < 4; i++)
			t[i] = -1;
		while (n < 200 && (t[0] < 0 || t[1] < 0 || t[2] < 0 || t[3] < 0)) begin
			@(negedge clk);
			n++;
			lc = {lc_power_on, lc_release_clk, lc_release_rst, lc_release_iso};
			for (int i = 0; i < 4; i++)
				if (lc[i] == level && t[i] < 0)
					t[i] = n;
		end
	endtask

	initial begin
		logic [7:0] a;
		logic [31:0] d, d_first;
		int s0, f0;
		int t[4];
		reset = 1'b1;
		din = 1'b1;
		tx_req = 1'b0;
		tx_priority = 1'b0;
		tx_addr = '0;
		tx_data = '0;
		rx_ack = 1'b0;
		req_int = 1'b0;
		wakeup_proc = 1'b1;	// keeps the node awake until the sleep test
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("dout after reset", 1, dout);
		check_value("strobes after reset", 0,
			{tx_ack, tx_succ, tx_fail, rx_req, rx_fail, rx_broadcast});
		check_value("lc after reset", 4'hf,
			{lc_power_on, lc_release_clk, lc_release_rst, lc_release_iso});
		check_on = 1'b1;

		begin_test("forwarding");
		for (int k = 0; k < 3; k++) begin
			a = rand_word(8);
			if (rx_ref(a, 1'b0) != 0)
				a = a ^ 8'h01;
			send_frame(a, rand_word(32));
			@(negedge clk);
			check_value("rx_req", 0, rx_req);
		end
		end_test();

		begin_test("receive");
		d = rand_word(32);
		send_frame(NODE_ADDR, d);
		@(negedge clk);
		check_value("rx_req", rx_ref(NODE_ADDR, 1'b0) == 1, rx_req);
		check_value("rx_addr", NODE_ADDR, rx_addr);
		check_value("rx_data", d, rx_data);
		check_value("rx_broadcast", 0, rx_broadcast);
		ack_rx();
		@(negedge clk);
		check_value("rx_req after ack", 0, rx_req);
		d_first = rand_word(32);
		send_frame(8'hff, d_first);
		@(negedge clk);
		check_value("rx_broadcast", 1, rx_broadcast);
		check_value("rx_data", d_first, rx_data);
		send_frame(NODE_ADDR, rand_word(32));	// nobody took the broadcast yet
		@(negedge clk);
		check_value("rx_fail", rx_ref(NODE_ADDR, 1'b1) == 2, rx_fail);
		check_value("rx_addr kept", 8'hff, rx_addr);
		check_value("rx_data kept", d_first, rx_data);
		ack_rx();
		repeat (4) @(posedge clk);
		end_test();

		begin_test("transmit");
		a = rand_word(8);
		d = rand_word(32);
		s0 = succ_cnt;
		exp_q.push_back(wire_ref(a, d));
		start_layer(a, d, 1'b0);
		wait_tx_done();
		check_value("tx_succ pulses", 1, succ_cnt - s0);
		end_test();

		begin_test("collision");
		a = rand_word(8);
		d = rand_word(32);
		s0 = succ_cnt;
		f0 = fail_cnt;
		exp_q.push_back(wire_ref(a, d));
		start_layer(a, d, 1'b0);
		repeat (12) @(posedge clk);	// into the data field
		send_frame(8'h33, rand_word(32));	// upstream node takes the ring
		repeat (3) @(posedge clk);
		check_value("tx_fail pulses", 1, fail_cnt - f0);
		check_value("no tx_succ", 0, succ_cnt - s0);
		check_value("rx_req", 0, rx_req);
		exp_q.push_back(wire_ref(a, d));
		start_layer(a, d, 1'b0);
		wait_tx_done();
		check_value("retry tx_succ", 1, succ_cnt - s0);
		end_test();

		begin_test("interrupt");
		exp_q.push_back(int_wire(12'd0));
		pulse_int();
		wait_tx_done();
		exp_q.push_back(int_wire(12'd1));
		pulse_int();
		wait_tx_done();
		a = rand_word(8);
		d = rand_word(32);
		exp_q.push_back(int_wire(12'd2));	// interrupt ahead of the layer
		exp_q.push_back(wire_ref(a, d));
		fork
			send_frame(8'h33, rand_word(32));
			begin
				repeat (4) @(posedge clk);
				pulse_int();
				start_layer(a, d, 1'b0);
			end
		join
		wait_tx_done();
		a = rand_word(8);
		d = rand_word(32);
		exp_q.push_back(wire_ref(a, d));	// priority puts the layer first
		exp_q.push_back(int_wire(12'd3));
		fork
			send_frame(8'h33, rand_word(32));
			begin
				repeat (4) @(posedge clk);
				pulse_int();
				start_layer(a, d, 1'b1);
			end
		join
		wait_tx_done();
		end_test();

		begin_test("sleep");
		@(posedge clk);
		wakeup_proc <= 1'b0;
		watch_lc(1'b0, t);
		// iso first reads low in the cycle after the last idle one
		check_value("cycles to iso fall", IDLE_LIMIT + 1, t[0]);
		check_value("rst after iso", STEP, t[1] - t[0]);
		check_value("clk after iso", 2 * STEP, t[2] - t[0]);
		check_value("power after iso", 3 * STEP, t[3] - t[0]);
		a = rand_word(8);
		d = rand_word(32);
		s0 = succ_cnt;
		exp_q.push_back(wire_ref(a, d));
		fork
			start_layer(a, d, 1'b0);
			watch_lc(1'b1, t);
		join
		check_value("clk after power", STEP, t[2] - t[3]);
		check_value("rst after power", 2 * STEP, t[1] - t[3]);
		check_value("iso after power", 3 * STEP, t[0] - t[3]);
		wait_tx_done();
		check_value("tx_succ after wake", 1, succ_cnt - s0);
		watch_lc(1'b0, t);
		check_value("asleep again", 0, lc_power_on);
		send_frame(NODE_ADDR, rand_word(32));
		@(negedge clk);
		check_value("rx_req while asleep", 0, rx_req);
		watch_lc(1'b1, t);
		check_value("awake after frame", 1, lc_release_iso);
		end_test();

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

/* verilog.f */
mbus_frame_pkg.sv
mbus_power_pkg.sv
mbus_node_ctrl.sv
mbus_tx_arbiter.sv
mbus_ext_int.sv
mbus_sleep_ctrl.sv
mbus_layer.sv
tb_mbus_layer.sv
